// File: common/des_pkg.sv
package des_pkg;

	// One 64-bit DES block, seen whole or as L/R halves
	typedef union packed {
		logic [63:0] block;      // Whole word for IP and FP
		struct packed {
			logic [31:0] l;      // Left half, bits 1..32
			logic [31:0] r;      // Right half, bits 33..64
		} half;
	} des_block_u;

	// Table entries use DES numbering, position 1 is the MSB
	localparam int ip_tab [64] = '{
		58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
		62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
		57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
		61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
	};

	localparam int fp_tab [64] = '{
		40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
		38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
		36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
		34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25
	};

	// Drops the eight parity bits of the key
	localparam int pc1_tab [56] = '{
		57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
		10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
		14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4
	};

	localparam int pc2_tab [48] = '{
		14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10, 23, 19, 12, 4,
		26, 8, 16, 7, 27, 20, 13, 2, 41, 52, 31, 37, 47, 55, 30, 40,
		51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
	};

	localparam int e_tab [48] = '{
		32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11,
		12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
		22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
	};

	localparam int p_tab [32] = '{
		16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
		2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25
	};

	// S1..S8, four rows of sixteen nibbles, entry 0 in the top nibble
	localparam logic [255:0] sbox_tab [8] = '{
		256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
		256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
		256'hA09E63F51DC7B428_D709346A285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
		256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
		256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
		256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
		256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
		256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B
	};

	// Left rotation of C and D per round
	localparam int shift_sched [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

	function automatic logic [63:0] ip_perm(logic [63:0] x);
		logic [63:0] y;
		for (int i = 0; i < 64; i++) begin
			y[63 - i] = x[64 - ip_tab[i]];
		end
		return y;
	endfunction

	function automatic logic [63:0] fp_perm(logic [63:0] x);
		logic [63:0] y;
		for (int i = 0; i < 64; i++) begin
			y[63 - i] = x[64 - fp_tab[i]];
		end
		return y;
	endfunction

	function automatic logic [55:0] pc1_perm(logic [63:0] x);
		logic [55:0] y;
		for (int i = 0; i < 56; i++) begin
			y[55 - i] = x[64 - pc1_tab[i]];
		end
		return y;
	endfunction

	function automatic logic [47:0] pc2_perm(logic [55:0] x);
		logic [47:0] y;
		for (int i = 0; i < 48; i++) begin
			y[47 - i] = x[56 - pc2_tab[i]];
		end
		return y;
	endfunction

	function automatic logic [47:0] e_expand(logic [31:0] x);
		logic [47:0] y;
		for (int i = 0; i < 48; i++) begin
			y[47 - i] = x[32 - e_tab[i]];
		end
		return y;
	endfunction

	function automatic logic [31:0] p_perm(logic [31:0] x);
		logic [31:0] y;
		for (int i = 0; i < 32; i++) begin
			y[31 - i] = x[32 - p_tab[i]];
		end
		return y;
	endfunction

	// Outer bits pick the row, inner four bits the column
	function automatic logic [3:0] sbox_lookup(logic [2:0] idx, logic [5:0] x);
		int pos;
		pos = {x[5], x[0], x[4:1]};
		return sbox_tab[idx][255 - 4 * pos -: 4];
	endfunction

endpackage

// File: common/des_load_if.sv
`timescale 1ns/1ps

// Job handoff from input stage to round engine
interface des_load_if;

	logic                load;   // One-cycle strobe, job valid
	des_pkg::des_block_u block;  // Message after IP
	logic [27:0]         c;      // Key half C after PC1
	logic [27:0]         d;      // Key half D after PC1

	modport src (
		output load,
		output block,
		output c,
		output d
	);

	modport dst (
		input load,
		input block,
		input c,
		input d
	);

endinterface

// File: des_engine/des_round_function.sv
`timescale 1ns/1ps

// Feistel f, one full round inside a single cycle
module des_round_function (
	input  logic [31:0] r,          // Right half of the current round
	input  logic [47:0] round_key,  // Key for this round
	output logic [31:0] f
);

	logic [47:0] r_exp;     // R after expansion
	logic [47:0] mixed;     // Expanded R xor key
	logic [31:0] s_out;     // Eight S-box nibbles, S1 on top

	// 32 to 48 bits, edge bits repeated
	assign r_exp = des_pkg::e_expand(r);

	// Key mix
	assign mixed = r_exp ^ round_key;

	// Each 6-bit group feeds its own box
	// S1 takes the top group and drives the top nibble
	for (genvar b = 0; b < 8; b++) begin : g_sbox
		assign s_out[31 - 4 * b -: 4] = des_pkg::sbox_lookup(3'(b), mixed[47 - 6 * b -: 6]);
	end

	// Final bit shuffle of the round
	assign f = des_pkg::p_perm(s_out);

endmodule

// File: des_engine/des_round_engine.sv
`timescale 1ns/1ps

// Sixteen Feistel rounds, one per clock, key schedule folded in
module des_round_engine (
	input  logic        clk,
	input  logic        rst_n,
	des_load_if.dst     ld,
	output logic        busy,   // Load cycle through fin cycle
	output logic        fin,    // Round 16 being computed
	output logic [31:0] l16,    // L after round 16
	output logic [31:0] r16     // R after round 16
);

	des_pkg::des_block_u lr_q;   // L/R state
	logic [27:0] c_q;            // Key half C
	logic [27:0] d_q;            // Key half D
	logic [27:0] c_rot;          // C rotated for this round
	logic [27:0] d_rot;          // D rotated for this round
	logic [47:0] round_key;
	logic [31:0] f_out;          // Feistel f of current R
	logic [3:0]  cnt_q;          // Round index, 0 means round 1
	logic        running;
	logic        last_round;

	assign last_round = running && (cnt_q == 4'd15);

	// Rotation by one or two places per schedule
	always_comb begin
		if (des_pkg::shift_sched[cnt_q] == 1) begin
			c_rot = {c_q[26:0], c_q[27]};
			d_rot = {d_q[26:0], d_q[27]};
		end else begin
			c_rot = {c_q[25:0], c_q[27:26]};
			d_rot = {d_q[25:0], d_q[27:26]};
		end
	end

	// Round key straight from the rotated pair
	assign round_key = des_pkg::pc2_perm({c_rot, d_rot});

	des_round_function u_round_function (
		.r         (lr_q.half.r),
		.round_key (round_key),
		.f         (f_out)
	);

	// Control, counter wraps from 15 back to 0 on the last round
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			cnt_q   <= 4'd0;
		end else if (ld.load) begin
			running <= 1'b1;
			cnt_q   <= 4'd0;
		end else if (running) begin
			cnt_q <= cnt_q + 4'd1;
			if (last_round)
				running <= 1'b0;  // Job leaves through fin
		end
	end

	// Datapath, load has priority over a round step
	always_ff @(posedge clk) begin
		if (ld.load) begin
			lr_q <= ld.block;
			c_q  <= ld.c;
			d_q  <= ld.d;
		end else if (running) begin
			lr_q.half.l <= lr_q.half.r;          // L gets old R
			lr_q.half.r <= lr_q.half.l ^ f_out;  // R gets L xor f
			c_q         <= c_rot;
			d_q         <= d_rot;
		end
	end

	assign busy = ld.load | running;
	assign fin  = last_round;

	// Round 16 result taken before it lands in the registers
	assign l16 = lr_q.half.r;
	assign r16 = lr_q.half.l ^ f_out;

endmodule

// File: source/des_input_stage.sv
`timescale 1ns/1ps

module des_input_stage (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,    // Job strobe from outside
	input  logic [63:0] message,  // Plaintext, valid with start
	input  logic [63:0] key,      // Key with parity bits, valid with start
	input  logic        busy,     // Engine still owns a job
	des_load_if.src     ld
);

	logic        accept;      // Start seen while engine idle
	logic [55:0] key_pc1;     // C and D side by side
	logic [63:0] msg_ip;      // Message after initial permutation

	// Starts during a running job are dropped here
	assign accept = start & ~busy;

	// Permutations are pure wiring ahead of the registers
	assign msg_ip  = des_pkg::ip_perm(message);
	assign key_pc1 = des_pkg::pc1_perm(key);

	// Load strobe, one cycle after the accepted start
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ld.load <= 1'b0;
		end else begin
			ld.load <= accept;
		end
	end

	// Job payload, held until the next accepted start
	always_ff @(posedge clk) begin
		if (accept) begin
			ld.block.block <= msg_ip;        // Whole-word view
			ld.c           <= key_pc1[55:28]; // Upper 28 bits form C
			ld.d           <= key_pc1[27:0];  // Lower 28 bits form D
		end
	end

endmodule

// File: source/des_output_stage.sv
`timescale 1ns/1ps

module des_output_stage (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        fin,      // Last round strobe from engine
	input  logic [31:0] l16,
	input  logic [31:0] r16,
	output logic        done,     // One cycle, result valid
	output logic [63:0] result    // Ciphertext, held until next done
);

	des_pkg::des_block_u swapped;   // R16 then L16

	// Final swap undoes the last Feistel exchange
	always_comb begin
		swapped.half.l = r16;
		swapped.half.r = l16;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done   <= 1'b0;
			result <= 64'd0;
		end else begin
			done <= fin;
			if (fin)
				result <= des_pkg::fp_perm(swapped.block);  // Inverse IP
		end
	end

endmodule

// File: source/des_cipher_top.sv
`timescale 1ns/1ps

// DES encryptor, input stage, round engine and output stage
module des_cipher_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  logic [63:0] message,
	input  logic [63:0] key,
	output logic        done,
	output logic [63:0] result,
	output logic        busy
);

	logic        fin;    // Engine finished round 16
	logic [31:0] l16;
	logic [31:0] r16;

	des_load_if ld_bus ();

	des_input_stage u_input_stage (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.message (message),
		.key     (key),
		.busy    (busy),
		.ld      (ld_bus.src)
	);

	des_round_engine u_round_engine (
		.clk   (clk),
		.rst_n (rst_n),
		.ld    (ld_bus.dst),
		.busy  (busy),     // Also seen at the boundary
		.fin   (fin),
		.l16   (l16),
		.r16   (r16)
	);

	des_output_stage u_output_stage (
		.clk    (clk),
		.rst_n  (rst_n),
		.fin    (fin),
		.l16    (l16),
		.r16    (r16),
		.done   (done),
		.result (result)
	);

endmodule

// File: dv/des_cipher_tb.sv
`timescale 1ns/1ps

module des_cipher_tb;

	localparam int max_wait = 40;   // Cycles any wait may take
	localparam int latency  = 18;   // Start strobe to done

	logic        clk;
	logic        rst_n;
	logic        start;
	logic [63:0] message;
	logic [63:0] key;
	logic        done;
	logic [63:0] result;
	logic        busy;

	logic [63:0] key_q [$];   // Trace columns
	logic [63:0] msg_q [$];
	logic [63:0] exp_q [$];
	logic [31:0] lcg_state;
	logic [63:0] held;        // Ciphertext that result must keep

	des_cipher_top dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.message (message),
		.key     (key),
		.done    (done),
		.result  (result),
		.busy    (busy)
	);

	always #2 clk = ~clk;  // 4 ns period

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic stop_fail(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "Testbench stopped at the first error");
	endtask

	// Comment lines start with a hash, blank lines skipped
	task automatic read_trace();
		int          fd;
		int          n;
		string       line;
		logic [63:0] k;
		logic [63:0] p;
		logic [63:0] c;
		fd = $fopen("dv/des_cipher_trace.txt", "r");
		if (fd == 0)
			stop_fail("Could not open the trace file dv/des_cipher_trace.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%h %h %h", k, p, c);
				if (n != 3)
					stop_fail($sformatf("Malformed trace line: %s", line));
				key_q.push_back(k);
				msg_q.push_back(p);
				exp_q.push_back(c);
			end
		end
		$fclose(fd);
		if (key_q.size() == 0)
			stop_fail("The trace file holds no vectors");
	endtask

	task automatic check_reset_state(input string phase);
		assert (done === 1'b0 && busy === 1'b0 && result === 64'd0) else
			stop_fail($sformatf("Mismatch at %0t: %s, done %b busy %b result %h, all zero expected",
				$time, phase, done, busy, result));
	endtask

	// Caller sits on a falling edge
	task automatic pulse_start(input logic [63:0] k, input logic [63:0] m);
		start   = 1'b1;
		key     = k;
		message = m;
	endtask

	// Counts falling edges after the start strobe, optional second start mid-job
	task automatic wait_done(input logic [63:0] exp, input int intrude_at);
		int          cyc;
		logic        seen;
		logic [63:0] first_msg;
		first_msg = message;
		cyc       = 0;
		seen      = 1'b0;
		while (!seen && cyc < max_wait) begin
			@(negedge clk);
			cyc++;
			start = 1'b0;
			if (intrude_at != 0 && cyc == intrude_at) begin
				start   = 1'b1;
				message = ~first_msg;    // Different job, must be dropped
				key     = {lcg_next(), lcg_next()};
			end
			seen = (done === 1'b1);
			if (!seen) begin
				assert (busy === 1'b1) else
					stop_fail($sformatf("Mismatch at %0t: busy low %0d cycles into a job",
						$time, cyc));
			end
		end
		if (!seen)
			stop_fail("Timeout: done did not arrive within 40 cycles of start");
		assert (cyc == latency) else
			stop_fail($sformatf("Mismatch at %0t: done after %0d cycles, expected %0d",
				$time, cyc, latency));
		assert (result === exp) else
			stop_fail($sformatf("Mismatch at %0t: result %h, expected %h",
				$time, result, exp));
		assert (busy === 1'b0) else
			stop_fail($sformatf("Mismatch at %0t: busy still high in done cycle", $time));
		held = result;
	endtask

	// Idle cycles with noise on message and key
	task automatic idle_gap(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			start   = 1'b0;
			key     = {lcg_next(), lcg_next()};
			message = {lcg_next(), lcg_next()};
			assert (done === 1'b0) else
				stop_fail($sformatf("Mismatch at %0t: done high in idle cycle %0d", $time, i));
			assert (busy === 1'b0) else
				stop_fail($sformatf("Mismatch at %0t: busy high in idle cycle %0d", $time, i));
			assert (result === held) else
				stop_fail($sformatf("Mismatch at %0t: result %h changed while idle, held %h",
					$time, result, held));
		end
	endtask

	initial begin
		int          gap;
		int          idx;
		int          intrude;
		logic [31:0] rnd;
		clk       = 1'b0;
		rst_n     = 1'b0;
		start     = 1'b0;
		message   = 64'd0;
		key       = 64'd0;
		lcg_state = 32'hc7f292ba;
		held      = 64'd0;
		read_trace();

		// Three cycles in reset
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			check_reset_state("in reset");
		end
		rst_n = 1'b1;
		@(negedge clk);
		check_reset_state("after reset");

		// Known answers, every fourth job starts in the done cycle
		for (int i = 0; i < key_q.size(); i++) begin
			pulse_start(key_q[i], msg_q[i]);
			wait_done(exp_q[i], 0);
			rnd = lcg_next();
			gap = int'(rnd[23:16]) % 6;
			if (i % 4 == 3)
				gap = 0;
			idle_gap(gap);
		end
		idle_gap(3);

		// Second start during a running job
		for (int j = 0; j < 3; j++) begin
			idx     = (j * 5) % key_q.size();
			rnd     = lcg_next();
			intrude = 2 + int'(rnd[15:8]) % 15;   // Cycles 2..16
			pulse_start(key_q[idx], msg_q[idx]);
			wait_done(exp_q[idx], intrude);
			idle_gap(20);                         // No second done
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: des_cipher.f
common/des_pkg.sv
common/des_load_if.sv
des_engine/des_round_function.sv
des_engine/des_round_engine.sv
source/des_input_stage.sv
source/des_output_stage.sv
source/des_cipher_top.sv
dv/des_cipher_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the DES testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f des_cipher.f \
	--top-module des_cipher_tb \
	-o des_cipher_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

if [ ! -x ./obj_dir/des_cipher_sim ]; then
	echo "Simulation binary not found"
	exit 1
fi

./obj_dir/des_cipher_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

echo "Simulation finished with status 0"
exit 0

// File: dv/des_cipher_trace.txt
# Columns: key plaintext expected_ciphertext, 64-bit hex each
# Standard case, weak keys, all-zero and all-one, published vectors
133457799BBCDFF1 0123456789ABCDEF 85E813540F0AB405
0000000000000000 0000000000000000 8CA64DE9C1B123A7
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 7359B2163E4EDC58
0101010101010101 0000000000000000 8CA64DE9C1B123A7
FEFEFEFEFEFEFEFE FFFFFFFFFFFFFFFF 7359B2163E4EDC58
0101010101010101 0123456789ABCDEF 617B3A0CE8F07100
1F1F1F1F0E0E0E0E 0123456789ABCDEF DB958605F8C8C606
0000000000000000 FFFFFFFFFFFFFFFF 355550B2150E2451
FFFFFFFFFFFFFFFF 0000000000000000 CAAAAF4DEAF1DBAE
3000000000000000 1000000000000001 958E6E627A05557B
1111111111111111 1111111111111111 F40379AB9E0EC533
0123456789ABCDEF 1111111111111111 17668DFC7292532D
1111111111111111 0123456789ABCDEF 8A5AE1F81AB8F2DD
FEDCBA9876543210 0123456789ABCDEF ED39D950FA74BCC4
7CA110454A1A6E57 01A1D6D039776742 690F5B0D9A26939B
0131D9619DC1376E 5CD54CA83DEF57DA 7A389D10354BD271
07A1133E4A0B2686 0248D43806F67172 868EBB51CAB4599A
3849674C2602319E 51454B582DDF440A 7178876E01F19B2A
